//--- Makefile
TOP := tb_issue_top

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"

test:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -o sim
	./obj_dir/sim > sim.log 2>&1; cat sim.log
	@if grep -q "=== FAIL ===" sim.log; then exit 1; fi
	@grep -q "=== PASS ===" sim.log

clean:
	rm -rf obj_dir sim.log

//--- instr_queue.sv
`timescale 1ns/1ps

module instr_queue
    import tomasulo_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  push_i,
    input  word_t pc_i,
    input  word_t instr_i,
    input  logic  pop_i,
    output logic  full_o,
    output logic  empty_o,
    output word_t head_pc_o,
    output word_t head_instr_o
);
    word_t pc_mem    [IQ_DEPTH];
    word_t instr_mem [IQ_DEPTH];
    logic [IQ_PTR_W-1:0] rd_ptr_q, wr_ptr_q;
    logic [IQ_PTR_W:0]   count_q;
    logic push_ok;

    assign full_o       = count_q == (IQ_PTR_W + 1)'(IQ_DEPTH);
    assign empty_o      = count_q == '0;
    assign push_ok      = push_i && !full_o;
    assign head_pc_o    = pc_mem[rd_ptr_q];
    assign head_instr_o = instr_mem[rd_ptr_q];

    // pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_ok) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (pop_i) rd_ptr_q <= rd_ptr_q + 1'b1;
            count_q <= count_q + (IQ_PTR_W + 1)'(push_ok) - (IQ_PTR_W + 1)'(pop_i);
        end
    end

    always_ff @(posedge clk) begin
        if (push_ok) begin
            pc_mem[wr_ptr_q]    <= pc_i;
            instr_mem[wr_ptr_q] <= instr_i;
        end
    end

    // the controller only pops a head it can see
    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst) pop_i |-> !empty_o)
        else $error("instr_queue popped while empty");
endmodule

//--- issue_ctrl.sv
`timescale 1ns/1ps

module issue_ctrl
    import tomasulo_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  word_t    head_pc_i,
    input  word_t    head_instr_i,
    input  logic     empty_i,
    output logic     pop_o,
    input  operand_t src_a_i,
    input  operand_t src_b_i,
    output reg_idx_t rs1_o,
    output reg_idx_t rs2_o,
    output logic     set_o,
    output reg_idx_t set_rd_o,
    input  tag_t     free_tag_i,
    input  logic     avail_i,
    output logic     alloc_o,
    station_if.issuer alu,
    station_if.issuer cmp
);
    opcode_t    opcode;
    logic [2:0] funct3;
    reg_idx_t   rd;
    word_t      i_imm, u_imm;
    logic       keep, to_cmp, issue, drop, station_free;
    alu_op_t    alu_op;
    operand_t   op_a, op_b;

    // instruction fields
    assign opcode = opcode_t'(head_instr_i[6:0]);
    assign rd     = head_instr_i[11:7];
    assign funct3 = head_instr_i[14:12];
    assign rs1_o  = head_instr_i[19:15];
    assign rs2_o  = head_instr_i[24:20];
    assign i_imm  = {{20{head_instr_i[31]}}, head_instr_i[31:20]};
    assign u_imm  = {head_instr_i[31:12], 12'h000};

    always_comb begin
        keep   = 1'b1;
        to_cmp = 1'b0;
        alu_op = alu_add;
        op_a   = src_a_i;
        op_b   = src_b_i;
        case (opcode)
            op_lui: begin
                op_a = '{value: '0, tag: '0};
                op_b = '{value: u_imm, tag: '0};
            end
            op_auipc: begin
                op_a = '{value: head_pc_i, tag: '0};
                op_b = '{value: u_imm, tag: '0};
            end
            op_imm: begin
                op_b   = '{value: i_imm, tag: '0};
                to_cmp = funct3[2:1] == 2'b01;
                // only the right shifts have an immediate variant
                if (!to_cmp)
                    alu_op = alu_op_t'({funct3 == 3'b101 && head_instr_i[30], funct3});
            end
            op_reg: begin
                to_cmp = funct3[2:1] == 2'b01;
                // add/sub and srl/sra share funct3
                if (!to_cmp) begin
                    alu_op = alu_op_t'({(funct3 == 3'b000 || funct3 == 3'b101)
                                        && head_instr_i[30], funct3});
                end
            end
            default: keep = 1'b0;
        endcase
    end

    // one decision drives pop, alloc, set and the station write
    assign station_free = to_cmp ? !cmp.full : !alu.full;
    assign drop     = !empty_i && (!keep || rd == '0);
    assign issue    = !empty_i && keep && rd != '0 && station_free && avail_i;
    assign pop_o    = issue || drop;
    assign alloc_o  = issue;
    assign set_o    = issue;
    assign set_rd_o = rd;

    assign alu.valid   = issue && !to_cmp;
    assign alu.payload = '{op: alu_op};
    assign alu.src_a   = op_a;
    assign alu.src_b   = op_b;
    assign alu.dest    = free_tag_i;

    assign cmp.valid   = issue && to_cmp;
    assign cmp.payload = '{op: cmp_op_t'(funct3[0])};
    assign cmp.src_a   = op_a;
    assign cmp.src_b   = op_b;
    assign cmp.dest    = free_tag_i;

    // a stalled head must stay in place until it leaves the queue
    a_head_held: assert property (@(posedge clk) disable iff (rst)
        (!empty_i && !pop_o) |=> $stable(head_instr_i))
        else $error("queue head changed during a stall");
endmodule

//--- issue_top.sv
`timescale 1ns/1ps

module issue_top
    import tomasulo_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    instr_valid_i,
    input  word_t   pc_i,
    input  word_t   instr_i,
    output logic    instr_full_o,
    input  logic    cdb_valid_i,
    input  tag_t    cdb_tag_i,
    input  word_t   cdb_value_i,
    output logic    alu_ex_valid_o,
    output alu_op_t alu_ex_op_o,
    output word_t   alu_ex_a_o,
    output word_t   alu_ex_b_o,
    output tag_t    alu_ex_tag_o,
    output logic    cmp_ex_valid_o,
    output cmp_op_t cmp_ex_op_o,
    output word_t   cmp_ex_a_o,
    output word_t   cmp_ex_b_o,
    output tag_t    cmp_ex_tag_o
);
    word_t      head_pc, head_instr;
    logic       iq_empty, iq_pop;
    reg_idx_t   rs1, rs2, set_rd;
    operand_t   src_a, src_b;
    logic       set_en, alloc, avail;
    tag_t       free_tag;
    alu_entry_t alu_ex_payload;
    cmp_entry_t cmp_ex_payload;

    station_if #(.payload_t(alu_entry_t)) alu_if ();
    station_if #(.payload_t(cmp_entry_t)) cmp_if ();

    instr_queue u_iq (
        .clk, .rst,
        .push_i       (instr_valid_i),
        .pc_i, .instr_i,
        .pop_i        (iq_pop),
        .full_o       (instr_full_o),
        .empty_o      (iq_empty),
        .head_pc_o    (head_pc),
        .head_instr_o (head_instr)
    );

    issue_ctrl u_ctrl (
        .clk, .rst,
        .head_pc_i (head_pc), .head_instr_i (head_instr), .empty_i (iq_empty),
        .pop_o     (iq_pop),
        .src_a_i   (src_a), .src_b_i (src_b), .rs1_o (rs1), .rs2_o (rs2),
        .set_o     (set_en), .set_rd_o (set_rd),
        .free_tag_i (free_tag), .avail_i (avail), .alloc_o (alloc),
        .alu       (alu_if.issuer),
        .cmp       (cmp_if.issuer)
    );

    reg_status u_regs (
        .clk, .rst,
        .rs1_i (rs1), .rs2_i (rs2), .src_a_o (src_a), .src_b_o (src_b),
        .set_i (set_en), .set_rd_i (set_rd), .set_tag_i (free_tag),
        .cdb_valid_i, .cdb_tag_i, .cdb_value_i
    );

    tag_pool u_tags (
        .clk, .rst,
        .alloc_i (alloc), .free_tag_o (free_tag), .avail_o (avail),
        .cdb_valid_i, .cdb_tag_i
    );

    res_station #(.payload_t(alu_entry_t)) u_alu_rs (
        .clk, .rst, .iss (alu_if.station),
        .cdb_valid_i, .cdb_tag_i, .cdb_value_i,
        .ex_valid_o (alu_ex_valid_o), .ex_payload_o (alu_ex_payload),
        .ex_a_o (alu_ex_a_o), .ex_b_o (alu_ex_b_o), .ex_tag_o (alu_ex_tag_o)
    );

    res_station #(.payload_t(cmp_entry_t)) u_cmp_rs (
        .clk, .rst, .iss (cmp_if.station),
        .cdb_valid_i, .cdb_tag_i, .cdb_value_i,
        .ex_valid_o (cmp_ex_valid_o), .ex_payload_o (cmp_ex_payload),
        .ex_a_o (cmp_ex_a_o), .ex_b_o (cmp_ex_b_o), .ex_tag_o (cmp_ex_tag_o)
    );

    // flatten payloads onto the plain top ports
    assign alu_ex_op_o = alu_ex_payload.op;
    assign cmp_ex_op_o = cmp_ex_payload.op;
endmodule

//--- reg_status.sv
`timescale 1ns/1ps

module reg_status
    import tomasulo_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  reg_idx_t rs1_i,
    input  reg_idx_t rs2_i,
    output operand_t src_a_o,
    output operand_t src_b_o,
    input  logic     set_i,
    input  reg_idx_t set_rd_i,
    input  tag_t     set_tag_i,
    input  logic     cdb_valid_i,
    input  tag_t     cdb_tag_i,
    input  word_t    cdb_value_i
);
    operand_t regs_q [NUM_REGS];

    // a broadcast of the producer in the read cycle counts as present
    function automatic operand_t lookup(operand_t r);
        if (cdb_valid_i && r.tag != '0 && r.tag == cdb_tag_i)
            return '{value: cdb_value_i, tag: '0};
        return r;
    endfunction

    assign src_a_o = lookup(regs_q[rs1_i]);
    assign src_b_o = lookup(regs_q[rs2_i]);

    // x0 is cleared by reset and never written
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < NUM_REGS; r++) regs_q[r] <= '{value: '0, tag: '0};
        end else begin
            for (int r = 1; r < NUM_REGS; r++) begin
                if (cdb_valid_i && regs_q[r].tag != '0 && regs_q[r].tag == cdb_tag_i)
                    regs_q[r] <= '{value: cdb_value_i, tag: '0};
                // new producer wins over a same-edge broadcast
                if (set_i && set_rd_i == reg_idx_t'(r)) regs_q[r].tag <= set_tag_i;
            end
        end
    end

    a_no_set_x0: assert property (@(posedge clk) disable iff (rst) set_i |-> set_rd_i != '0)
        else $error("tag recorded against x0");
endmodule

//--- res_station.sv
`timescale 1ns/1ps

module res_station
    import tomasulo_pkg::*;
#(
    parameter type payload_t = alu_entry_t
) (
    input  logic     clk,
    input  logic     rst,
    station_if.station iss,
    input  logic     cdb_valid_i,
    input  tag_t     cdb_tag_i,
    input  word_t    cdb_value_i,
    output logic     ex_valid_o,
    output payload_t ex_payload_o,
    output word_t    ex_a_o,
    output word_t    ex_b_o,
    output tag_t     ex_tag_o
);
    logic [RS_DEPTH-1:0] busy_q, ready;
    payload_t payload_q [RS_DEPTH];
    operand_t src_a_q   [RS_DEPTH];
    operand_t src_b_q   [RS_DEPTH];
    tag_t     dest_q    [RS_DEPTH];
    logic [RS_IDX_W-1:0] wr_idx, sel_idx;
    logic sel_valid;

    // lowest free slot for writes, lowest ready slot for dispatch
    always_comb begin
        wr_idx    = '0;
        sel_idx   = '0;
        sel_valid = 1'b0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            ready[i] = busy_q[i] && src_a_q[i].tag == '0 && src_b_q[i].tag == '0;
            if (!busy_q[i]) wr_idx = RS_IDX_W'(i);
            if (ready[i]) begin
                sel_idx   = RS_IDX_W'(i);
                sel_valid = 1'b1;
            end
        end
    end

    assign iss.full = &busy_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q     <= '0;
            ex_valid_o <= 1'b0;
        end else begin
            ex_valid_o <= sel_valid;
            if (sel_valid) busy_q[sel_idx] <= 1'b0;
            if (iss.valid) busy_q[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        // waiting operands grab their value off the CDB
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (cdb_valid_i && src_a_q[i].tag != '0 && src_a_q[i].tag == cdb_tag_i)
                src_a_q[i] <= '{value: cdb_value_i, tag: '0};
            if (cdb_valid_i && src_b_q[i].tag != '0 && src_b_q[i].tag == cdb_tag_i)
                src_b_q[i] <= '{value: cdb_value_i, tag: '0};
        end
        if (iss.valid) begin
            payload_q[wr_idx] <= iss.payload;
            src_a_q[wr_idx]   <= iss.src_a;
            src_b_q[wr_idx]   <= iss.src_b;
            dest_q[wr_idx]    <= iss.dest;
        end
        if (sel_valid) begin
            ex_payload_o <= payload_q[sel_idx];
            ex_a_o       <= src_a_q[sel_idx].value;
            ex_b_o       <= src_b_q[sel_idx].value;
            ex_tag_o     <= dest_q[sel_idx];
        end
    end

    a_no_write_full: assert property (@(posedge clk) disable iff (rst) iss.valid |-> !iss.full)
        else $error("write into a full reservation station");
endmodule

//--- station_if.sv
`timescale 1ns/1ps

// issue controller to reservation station, one write per cycle
interface station_if
    import tomasulo_pkg::*;
#(
    parameter type payload_t = alu_entry_t
);
    logic     valid;
    payload_t payload;
    operand_t src_a;
    operand_t src_b;
    tag_t     dest;
    // every entry occupied
    logic     full;

    modport issuer (
        output valid, payload, src_a, src_b, dest,
        input  full
    );

    modport station (
        input  valid, payload, src_a, src_b, dest,
        output full
    );
endinterface

//--- tag_pool.sv
`timescale 1ns/1ps

module tag_pool
    import tomasulo_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic alloc_i,
    output tag_t free_tag_o,
    output logic avail_o,
    input  logic cdb_valid_i,
    input  tag_t cdb_tag_i
);
    // bit t set means tag t is free
    logic [NUM_TAGS:1] free_q;

    assign avail_o = |free_q;

    // lowest free tag first
    always_comb begin
        free_tag_o = '0;
        for (int t = NUM_TAGS; t >= 1; t--) begin
            if (free_q[t]) free_tag_o = tag_t'(t);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            free_q <= '1;
        end else begin
            if (cdb_valid_i && cdb_tag_i != '0) free_q[cdb_tag_i] <= 1'b1;
            if (alloc_i && avail_o) free_q[free_tag_o] <= 1'b0;
        end
    end

    a_release_busy: assert property (@(posedge clk) disable iff (rst)
        cdb_valid_i |-> (cdb_tag_i != '0 && !free_q[cdb_tag_i]))
        else $error("CDB released tag %0d that was not in flight", cdb_tag_i);
endmodule

//--- tb.f
tomasulo_pkg.sv
station_if.sv
instr_queue.sv
issue_ctrl.sv
reg_status.sv
tag_pool.sv
res_station.sv
issue_top.sv
tb_issue_top.sv

//--- tb_issue_top.sv
`timescale 1ns/1ps

module tb_issue_top
    import tomasulo_pkg::*;
;
    localparam int TIMEOUT_CYCLES = 2000;

    typedef struct packed {
        logic     cmp;
        logic [3:0] op;
        operand_t a;
        operand_t b;
        tag_t     dest;
    } pend_t;

    logic clk, rst, instr_valid, cdb_valid;
    logic rst_d = 1'b1;
    word_t pc, instr, cdb_value, next_pc;
    tag_t cdb_tag;
    logic instr_full_o, alu_ex_valid_o, cmp_ex_valid_o;
    alu_op_t alu_ex_op_o;
    cmp_op_t cmp_ex_op_o;
    word_t alu_ex_a_o, alu_ex_b_o, cmp_ex_a_o, cmp_ex_b_o;
    tag_t alu_ex_tag_o, cmp_ex_tag_o;
    int errors, err_mark, n_checks, cycles;

    // reference model state
    word_t mval [32];
    tag_t  mtag [32];
    logic [7:1] mfree;
    logic [70:0] exp_alu [$];
    logic [70:0] exp_cmp [$];
    pend_t waiting [$];
    logic [63:0] unissued [$];

    issue_top u_dut (
        .clk, .rst, .instr_valid_i (instr_valid), .pc_i (pc), .instr_i (instr),
        .instr_full_o, .cdb_valid_i (cdb_valid), .cdb_tag_i (cdb_tag),
        .cdb_value_i (cdb_value),
        .alu_ex_valid_o, .alu_ex_op_o, .alu_ex_a_o, .alu_ex_b_o, .alu_ex_tag_o,
        .cmp_ex_valid_o, .cmp_ex_op_o, .cmp_ex_a_o, .cmp_ex_b_o, .cmp_ex_tag_o
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        rst_d <= rst;
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run went past %0d cycles", TIMEOUT_CYCLES);
            $display("=== FAIL ===");
            $finish;
        end
    end

    function automatic logic alu_head_ok();
        return exp_alu.size() != 0
            && exp_alu[0] == {alu_ex_op_o, alu_ex_a_o, alu_ex_b_o, alu_ex_tag_o};
    endfunction

    function automatic logic cmp_head_ok();
        return exp_cmp.size() != 0
            && exp_cmp[0] == {3'b000, cmp_ex_op_o, cmp_ex_a_o, cmp_ex_b_o, cmp_ex_tag_o};
    endfunction

    // outputs are checked mid-cycle and queues advance at the next edge
    a_alu_pulse: assert property (@(negedge clk) disable iff (rst) alu_ex_valid_o |-> alu_head_ok())
        else begin
            errors++;
            $display("mismatch at %0t: alu op %0d a %h b %h tag %0d", $time, alu_ex_op_o,
                     alu_ex_a_o, alu_ex_b_o, alu_ex_tag_o);
        end

    a_cmp_pulse: assert property (@(negedge clk) disable iff (rst) cmp_ex_valid_o |-> cmp_head_ok())
        else begin
            errors++;
            $display("mismatch at %0t: cmp op %0d a %h b %h tag %0d", $time, cmp_ex_op_o,
                     cmp_ex_a_o, cmp_ex_b_o, cmp_ex_tag_o);
        end

    a_quiet_reset: assert property (@(negedge clk)
        (rst || rst_d) |-> !alu_ex_valid_o && !cmp_ex_valid_o && !instr_full_o)
        else begin
            errors++;
            $display("dispatch or queue full seen during reset at %0t", $time);
        end

    always @(posedge clk) begin
        if (!rst && alu_ex_valid_o && exp_alu.size() != 0) begin
            void'(exp_alu.pop_front());
            n_checks++;
        end
        if (!rst && cmp_ex_valid_o && exp_cmp.size() != 0) begin
            void'(exp_cmp.pop_front());
            n_checks++;
        end
    end

    function automatic operand_t read_reg(reg_idx_t r);
        if (mtag[r] != '0)
            return '{value: '0, tag: mtag[r]};
        return '{value: mval[r], tag: '0};
    endfunction

    task automatic file_entry(input pend_t e);
        if (e.a.tag != '0 || e.b.tag != '0)
            waiting.push_back(e);
        else if (e.cmp)
            exp_cmp.push_back({e.op, e.a.value, e.b.value, e.dest});
        else
            exp_alu.push_back({e.op, e.a.value, e.b.value, e.dest});
    endtask

    // decode one instruction into its expected station entry
    // popped is low when no tag is free
    task automatic model_issue(input word_t ipc, input word_t ins, output logic popped);
        logic [2:0] f3;
        reg_idx_t rd;
        logic keep;
        pend_t e;
        tag_t t;
        f3 = ins[14:12];
        rd = ins[11:7];
        keep = 1'b1;
        e.cmp = 1'b0;
        e.op = alu_add;
        e.a = read_reg(ins[19:15]);
        e.b = read_reg(ins[24:20]);
        case (ins[6:0])
            7'b0110111: begin
                e.a = '{value: '0, tag: '0};
                e.b = '{value: {ins[31:12], 12'h000}, tag: '0};
            end
            7'b0010111: begin
                e.a = '{value: ipc, tag: '0};
                e.b = '{value: {ins[31:12], 12'h000}, tag: '0};
            end
            7'b0010011, 7'b0110011: begin
                if (ins[6:0] == 7'b0010011)
                    e.b = '{value: {{20{ins[31]}}, ins[31:20]}, tag: '0};
                case (f3)
                    3'b000: e.op = (ins[5] && ins[30]) ? alu_sub : alu_add;
                    3'b001: e.op = alu_sll;
                    3'b010: e.cmp = 1'b1;
                    3'b011: e.cmp = 1'b1;
                    3'b100: e.op = alu_xor;
                    3'b101: e.op = ins[30] ? alu_sra : alu_srl;
                    3'b110: e.op = alu_or;
                    default: e.op = alu_and;
                endcase
                if (e.cmp)
                    e.op = f3[0] ? 4'(cmp_ltu) : 4'(cmp_lt);
            end
            default: keep = 1'b0;
        endcase
        popped = 1'b1;
        if (!keep || rd == '0)
            return;
        t = '0;
        for (int i = 7; i >= 1; i--) begin
            if (mfree[i]) t = tag_t'(i);
        end
        if (t == '0) begin
            popped = 1'b0;
            return;
        end
        mfree[t] = 1'b0;
        e.dest = t;
        mtag[rd] = t;
        file_entry(e);
    endtask

    task automatic try_issue();
        logic popped;
        while (unissued.size() != 0) begin
            model_issue(unissued[0][63:32], unissued[0][31:0], popped);
            if (!popped)
                break;
            void'(unissued.pop_front());
        end
    endtask

    task automatic model_broadcast(input tag_t t, input word_t v);
        pend_t still [$];
        pend_t e;
        for (int r = 1; r < 32; r++) begin
            if (mtag[r] == t) begin
                mval[r] = v;
                mtag[r] = '0;
            end
        end
        mfree[t] = 1'b1;
        while (waiting.size() != 0) begin
            e = waiting.pop_front();
            if (e.a.tag == t)
                e.a = '{value: v, tag: '0};
            if (e.b.tag == t)
                e.b = '{value: v, tag: '0};
            if (e.a.tag == '0 && e.b.tag == '0)
                file_entry(e);
            else
                still.push_back(e);
        end
        waiting = still;
        try_issue();
    endtask

    // push applies one edge after it is driven
    task automatic push_instr(input word_t ins);
        @(negedge clk);
        while (instr_full_o) @(negedge clk);
        @(posedge clk);
        instr_valid <= 1'b1;
        pc <= next_pc;
        instr <= ins;
        @(posedge clk);
        instr_valid <= 1'b0;
        unissued.push_back({next_pc, ins});
        next_pc = next_pc + 32'd4;
        try_issue();
    endtask

    task automatic broadcast(input tag_t t, input word_t v);
        cdb_valid <= 1'b1;
        cdb_tag <= t;
        cdb_value <= v;
        @(posedge clk);
        cdb_valid <= 1'b0;
        model_broadcast(t, v);
    endtask

    // frees every tag in flight, lowest first, then waits for the stations
    task automatic release_all();
        tag_t t;
        repeat (3) @(posedge clk);
        while (mfree != 7'h7f || unissued.size() != 0) begin
            t = '0;
            for (int i = 7; i >= 1; i--) begin
                if (!mfree[i]) t = tag_t'(i);
            end
            broadcast(t, $urandom);
            repeat (2) @(posedge clk);
        end
        while (exp_alu.size() != 0 || exp_cmp.size() != 0 || waiting.size() != 0)
            @(posedge clk);
    endtask

    function automatic reg_idx_t pick(int lo, int hi);
        return reg_idx_t'(lo + int'($urandom % (hi - lo + 1)));
    endfunction

    function automatic word_t enc_u(logic [6:0] opc, reg_idx_t rd);
        return {20'($urandom), rd, opc};
    endfunction

    function automatic word_t enc_i(logic [2:0] f3, reg_idx_t rd, reg_idx_t rs1, logic [11:0] imm);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic word_t enc_r(logic [2:0] f3, logic alt, reg_idx_t rd, reg_idx_t rs1,
                                    reg_idx_t rs2);
        return {1'b0, alt, 5'b00000, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    task automatic report(input string name);
        $display("test %-14s done, %0d errors", name, errors - err_mark);
        err_mark = errors;
    endtask

    initial begin
        tag_t ta;
        void'($urandom(98));
        rst = 1'b1;
        instr_valid = 1'b0;
        pc = '0;
        instr = '0;
        cdb_valid = 1'b0;
        cdb_tag = '0;
        cdb_value = '0;
        next_pc = 32'h0000_1000;
        errors = 0;
        err_mark = 0;
        n_checks = 0;
        cycles = 0;
        mfree = 7'h7f;
        for (int r = 0; r < 32; r++) begin
            mval[r] = '0;
            mtag[r] = '0;
        end
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        repeat (2) @(posedge clk);
        report("reset");

        // wakeup by a later broadcast, then one in the issue cycle
        push_instr(enc_u(7'b0110111, 5'd20));
        ta = mtag[20];
        push_instr(enc_r(3'b000, 1'b0, 5'd21, 5'd20, pick(22, 31)));
        repeat (3) @(posedge clk);
        broadcast(ta, $urandom);
        push_instr(enc_u(7'b0110111, 5'd23));
        ta = mtag[23];
        repeat (3) @(posedge clk);
        push_instr(enc_i(3'b000, 5'd24, 5'd23, 12'($urandom)));
        broadcast(ta, $urandom);
        release_all();
        report("dependency");

        push_instr(enc_u(7'b0110111, pick(1, 15)));
        push_instr(enc_u(7'b0010111, pick(1, 15)));
        push_instr(enc_i(3'b000, pick(1, 15), pick(16, 31), 12'($urandom)));
        push_instr(enc_i(3'b100, pick(1, 15), pick(16, 31), 12'($urandom)));
        push_instr(enc_i(3'b101, pick(1, 15), pick(16, 31), {7'b0000000, 5'($urandom)}));
        push_instr(enc_i(3'b101, pick(1, 15), pick(16, 31), {7'b0100000, 5'($urandom)}));
        push_instr(enc_r(3'b000, 1'b0, pick(1, 15), pick(16, 31), pick(16, 31)));
        push_instr(enc_r(3'b000, 1'b1, pick(1, 15), pick(16, 31), pick(16, 31)));
        push_instr(enc_r(3'b101, 1'b1, pick(1, 15), pick(16, 31), pick(16, 31)));
        release_all();
        report("alu");

        push_instr(enc_r(3'b010, 1'b0, pick(1, 15), pick(16, 31), pick(16, 31)));
        push_instr(enc_r(3'b011, 1'b0, pick(1, 15), pick(16, 31), pick(16, 31)));
        push_instr(enc_i(3'b010, pick(1, 15), pick(16, 31), 12'($urandom)));
        push_instr(enc_i(3'b011, pick(1, 15), pick(16, 31), 12'($urandom)));
        release_all();
        report("compare");

        // seven tags issue, the eighth stalls and the queue fills behind it
        for (int i = 0; i < 11; i++)
            push_instr(enc_u(7'b0110111, pick(1, 15)));
        @(negedge clk);
        a_queue_full: assert (instr_full_o)
            else begin
                errors++;
                $display("instr_full_o stayed low with all tags in flight at %0t", $time);
            end
        @(posedge clk);
        release_all();
        report("backpressure");

        push_instr(enc_i(3'b000, 5'd0, pick(16, 31), 12'($urandom)));
        push_instr({7'd0, 5'd3, 5'd4, 3'b010, 5'd0, 7'b0100011});
        push_instr(enc_u(7'b0110111, 5'd5));
        release_all();
        report("dropped");

        $display("checks %0d, errors %0d", n_checks, errors);
        if (errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end
endmodule

//--- tomasulo_pkg.sv
package tomasulo_pkg;

    // machine sizes
    localparam int NUM_TAGS = 7;
    localparam int NUM_REGS = 32;
    localparam int IQ_DEPTH = 4;
    localparam int RS_DEPTH = 4;
    localparam int IQ_PTR_W = $clog2(IQ_DEPTH);
    localparam int RS_IDX_W = $clog2(RS_DEPTH);

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    // tag 0 means the value is already present
    typedef logic [2:0]  tag_t;

    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } opcode_t;

    // low three bits follow funct3, bit 3 is the instr[30] variant
    typedef enum logic [3:0] {
        alu_add = 4'b0000,
        alu_sll = 4'b0001,
        alu_xor = 4'b0100,
        alu_srl = 4'b0101,
        alu_or  = 4'b0110,
        alu_and = 4'b0111,
        alu_sub = 4'b1000,
        alu_sra = 4'b1101
    } alu_op_t;

    // funct3[0] picks unsigned
    typedef enum logic {
        cmp_lt  = 1'b0,
        cmp_ltu = 1'b1
    } cmp_op_t;

    typedef struct packed {
        word_t value;
        tag_t  tag;
    } operand_t;

    typedef struct packed {
        alu_op_t op;
    } alu_entry_t;

    typedef struct packed {
        cmp_op_t op;
    } cmp_entry_t;

endpackage
